/* hw/isa_pkg.sv */
package isa_pkg;

    // 3R group, inst[31:15].
    localparam logic [16:0] OP_3R_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_3R_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_3R_SLT     = 17'h00024;
    localparam logic [16:0] OP_3R_SLTU    = 17'h00025;
    localparam logic [16:0] OP_3R_AND     = 17'h00029;
    localparam logic [16:0] OP_3R_OR      = 17'h0002A;
    localparam logic [16:0] OP_3R_XOR     = 17'h0002B;
    localparam logic [16:0] OP_3R_BREAK   = 17'h00054;
    localparam logic [16:0] OP_3R_SYSCALL = 17'h00056;

    // 2RI12 group, inst[31:22].
    localparam logic [9:0] OP_2RI12_SLTI   = 10'h008;
    localparam logic [9:0] OP_2RI12_ADDI_W = 10'h00A;
    localparam logic [9:0] OP_2RI12_ANDI   = 10'h00D;
    localparam logic [9:0] OP_2RI12_ORI    = 10'h00E;
    localparam logic [9:0] OP_2RI12_LD_W   = 10'h0A2;
    localparam logic [9:0] OP_2RI12_ST_W   = 10'h0A6;

    localparam logic [6:0] OP_1RI20_LU12I_W   = 7'h0A; // inst[31:25].
    localparam logic [6:0] OP_1RI20_PCADDU12I = 7'h0E;

    localparam logic [5:0] OP_2RI16_JIRL = 6'h13; // inst[31:26].
    localparam logic [5:0] OP_2RI16_BEQ  = 6'h16;
    localparam logic [5:0] OP_2RI16_BNE  = 6'h17;
    localparam logic [5:0] OP_2RI16_BLT  = 6'h18;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD_W, ALU_SUB_W, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SYSCALL, ALU_BREAK,
        ALU_ADDI_W, ALU_SLTI, ALU_ANDI, ALU_ORI, ALU_LD_W, ALU_ST_W,
        ALU_LU12I_W, ALU_PCADDU12I,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_JIRL
    } alu_op_t;

    // ecode values as in the privileged spec.
    typedef enum logic [5:0] {
        EXC_NOP = 6'h00,
        EXC_SYS = 6'h0B,
        EXC_BRK = 6'h0C,
        EXC_INE = 6'h0D
    } exc_cause_t;

endpackage

/* hw/pipe_pkg.sv */
package pipe_pkg;

    localparam int XLEN      = 32;
    localparam int INST_W    = 32;
    localparam int REG_AW    = 5;
    localparam int EXC_CW    = $bits(isa_pkg::exc_cause_t);
    localparam int EXC_UP    = 2; // slots raised before decode.
    localparam int EXC_SLOTS = EXC_UP + 1;

    // slot 1 address error, slot 2 tlb error.
    typedef struct packed {
        logic [XLEN-1:0]                pc;
        logic [INST_W-1:0]              inst;
        logic                           pre_is_branch_taken;
        logic [XLEN-1:0]                pre_branch_addr;
        logic [EXC_UP-1:0]              is_exception;
        logic [EXC_UP-1:0][EXC_CW-1:0]  exception_cause;
    } fetch_packet_t;

    typedef struct packed {
        logic                 hit;
        isa_pkg::alu_op_t     aluop;
        logic [REG_AW-1:0]    rd;
        logic [REG_AW-1:0]    rj;
        logic [REG_AW-1:0]    rk;
        logic [XLEN-1:0]      imm;
        logic                 use_imm;
        logic                 reg_write;
        logic                 is_branch;
        logic                 is_mem;
    } dec_part_t;

    typedef struct packed {
        isa_pkg::alu_op_t                  aluop;
        logic [REG_AW-1:0]                 rd;
        logic [REG_AW-1:0]                 rj;
        logic [REG_AW-1:0]                 rk;
        logic [XLEN-1:0]                   imm;
        logic                              use_imm;
        logic                              reg_write;
        logic                              is_branch;
        logic                              is_mem;
        logic [XLEN-1:0]                   pc;
        logic                              valid;
        logic                              pre_is_branch_taken;
        logic [XLEN-1:0]                   pre_branch_addr;
        logic [EXC_SLOTS-1:0]              is_exception;
        logic [EXC_SLOTS-1:0][EXC_CW-1:0]  exception_cause; // slot 0 is decode.
    } id_dispatch_t;

endpackage

/* hw/pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else begin
            valid_o <= valid_i & ~flush_i; // flush drops the packet.
            if (valid_i) begin
                data_o <= data_i;
            end
        end
    end

endmodule

/* hw/dec_reg_fmt.sv */
module dec_reg_fmt (
    input  logic [pipe_pkg::INST_W-1:0] inst_i,
    output pipe_pkg::dec_part_t         part_o
);

    logic [16:0] op;

    assign op = inst_i[31:15];

    always_comb begin
        part_o           = '0;
        part_o.hit       = 1'b1;
        part_o.rd        = inst_i[4:0];
        part_o.rj        = inst_i[9:5];
        part_o.rk        = inst_i[14:10];
        part_o.reg_write = 1'b1;
        case (op)
            isa_pkg::OP_3R_ADD_W: begin
                part_o.aluop = isa_pkg::ALU_ADD_W;
            end
            isa_pkg::OP_3R_SUB_W: begin
                part_o.aluop = isa_pkg::ALU_SUB_W;
            end
            isa_pkg::OP_3R_SLT: begin
                part_o.aluop = isa_pkg::ALU_SLT;
            end
            isa_pkg::OP_3R_SLTU: begin
                part_o.aluop = isa_pkg::ALU_SLTU;
            end
            isa_pkg::OP_3R_AND: begin
                part_o.aluop = isa_pkg::ALU_AND;
            end
            isa_pkg::OP_3R_OR: begin
                part_o.aluop = isa_pkg::ALU_OR;
            end
            isa_pkg::OP_3R_XOR: begin
                part_o.aluop = isa_pkg::ALU_XOR;
            end
            // code field sits in the register slots, so they are cleared.
            isa_pkg::OP_3R_SYSCALL: begin
                part_o.aluop     = isa_pkg::ALU_SYSCALL;
                part_o.rd        = '0;
                part_o.rj        = '0;
                part_o.rk        = '0;
                part_o.reg_write = 1'b0;
            end
            isa_pkg::OP_3R_BREAK: begin
                part_o.aluop     = isa_pkg::ALU_BREAK;
                part_o.rd        = '0;
                part_o.rj        = '0;
                part_o.rk        = '0;
                part_o.reg_write = 1'b0;
            end
            default: begin
                part_o = '0;
            end
        endcase
    end

endmodule

/* hw/dec_imm_fmt.sv */
module dec_imm_fmt (
    input  logic [pipe_pkg::INST_W-1:0] inst_i,
    output pipe_pkg::dec_part_t         part_o
);

    logic        hit_ri12;
    logic        hit_ri20;
    logic        hit_ri16;
    logic        zext12;
    logic [11:0] si12;
    logic [19:0] si20;
    logic [15:0] offs16;

    assign si12   = inst_i[21:10];
    assign si20   = inst_i[24:5];
    assign offs16 = inst_i[25:10];

    always_comb begin
        part_o           = '0;
        hit_ri12         = 1'b1;
        hit_ri20         = 1'b1;
        hit_ri16         = 1'b1;
        zext12           = 1'b0;
        part_o.rd        = inst_i[4:0];
        part_o.use_imm   = 1'b1;
        part_o.reg_write = 1'b1;

        case (inst_i[31:22])
            isa_pkg::OP_2RI12_ADDI_W: part_o.aluop = isa_pkg::ALU_ADDI_W;
            isa_pkg::OP_2RI12_SLTI:   part_o.aluop = isa_pkg::ALU_SLTI;
            isa_pkg::OP_2RI12_LD_W: begin
                part_o.aluop  = isa_pkg::ALU_LD_W;
                part_o.is_mem = 1'b1;
            end
            isa_pkg::OP_2RI12_ST_W: begin
                part_o.aluop     = isa_pkg::ALU_ST_W;
                part_o.is_mem    = 1'b1;
                part_o.reg_write = 1'b0; // rd is the store data.
            end
            isa_pkg::OP_2RI12_ANDI: begin
                part_o.aluop = isa_pkg::ALU_ANDI;
                zext12       = 1'b1;
            end
            isa_pkg::OP_2RI12_ORI: begin
                part_o.aluop = isa_pkg::ALU_ORI;
                zext12       = 1'b1;
            end
            default: hit_ri12 = 1'b0;
        endcase

        case (inst_i[31:25])
            isa_pkg::OP_1RI20_LU12I_W:   part_o.aluop = isa_pkg::ALU_LU12I_W;
            isa_pkg::OP_1RI20_PCADDU12I: part_o.aluop = isa_pkg::ALU_PCADDU12I;
            default:                     hit_ri20 = 1'b0;
        endcase

        part_o.is_branch = 1'b1;
        case (inst_i[31:26])
            isa_pkg::OP_2RI16_JIRL: part_o.aluop = isa_pkg::ALU_JIRL;
            isa_pkg::OP_2RI16_BEQ:  part_o.aluop = isa_pkg::ALU_BEQ;
            isa_pkg::OP_2RI16_BNE:  part_o.aluop = isa_pkg::ALU_BNE;
            isa_pkg::OP_2RI16_BLT:  part_o.aluop = isa_pkg::ALU_BLT;
            default: begin
                hit_ri16         = 1'b0;
                part_o.is_branch = 1'b0;
            end
        endcase

        if (hit_ri12) begin
            part_o.rj  = inst_i[9:5];
            part_o.imm = zext12 ? {20'b0, si12} : {{20{si12[11]}}, si12};
        end else if (hit_ri16) begin
            part_o.rj        = inst_i[9:5];
            part_o.imm       = {{14{offs16[15]}}, offs16, 2'b00};
            part_o.reg_write = (part_o.aluop == isa_pkg::ALU_JIRL); // only jirl links.
        end else if (hit_ri20) begin
            part_o.imm = {si20, 12'b0};
        end

        part_o.hit = hit_ri12 | hit_ri20 | hit_ri16;
        if (!part_o.hit) begin
            part_o = '0;
        end
    end

endmodule

/* hw/id.sv */
module id (
    input  logic                    valid_i,
    input  pipe_pkg::fetch_packet_t fetch_i,
    output pipe_pkg::id_dispatch_t  id_o
);

    pipe_pkg::dec_part_t  reg_part;
    pipe_pkg::dec_part_t  imm_part;
    pipe_pkg::dec_part_t  sel;
    logic                 ine;
    logic                 dec_exc;
    isa_pkg::exc_cause_t  dec_cause;

    dec_reg_fmt u_dec_reg (
        .inst_i (fetch_i.inst),
        .part_o (reg_part)
    );

    dec_imm_fmt u_dec_imm (
        .inst_i (fetch_i.inst),
        .part_o (imm_part)
    );

    assign ine = ~(reg_part.hit | imm_part.hit);

    always_comb begin
        sel       = '0;
        sel.aluop = isa_pkg::ALU_NOP;
        if (reg_part.hit) begin
            sel = reg_part;
        end else if (imm_part.hit) begin
            sel = imm_part;
        end
    end

    // decode slot cause.
    always_comb begin
        if (ine) begin
            dec_cause = isa_pkg::EXC_INE;
        end else if (sel.aluop == isa_pkg::ALU_SYSCALL) begin
            dec_cause = isa_pkg::EXC_SYS;
        end else if (sel.aluop == isa_pkg::ALU_BREAK) begin
            dec_cause = isa_pkg::EXC_BRK;
        end else begin
            dec_cause = isa_pkg::EXC_NOP;
        end
    end

    assign dec_exc = (dec_cause != isa_pkg::EXC_NOP);

    always_comb begin
        id_o                     = '0;
        id_o.aluop               = sel.aluop;
        id_o.rd                  = sel.rd;
        id_o.rj                  = sel.rj;
        id_o.rk                  = sel.rk;
        id_o.imm                 = sel.imm;
        id_o.use_imm             = sel.use_imm;
        id_o.reg_write           = sel.reg_write;
        id_o.is_branch           = sel.is_branch;
        id_o.is_mem              = sel.is_mem;
        id_o.pc                  = fetch_i.pc;
        id_o.valid               = valid_i;
        id_o.pre_is_branch_taken = fetch_i.pre_is_branch_taken;
        id_o.pre_branch_addr     = fetch_i.pre_branch_addr;
        id_o.is_exception        = {fetch_i.is_exception, dec_exc};
        id_o.exception_cause     = {fetch_i.exception_cause, dec_cause}; // upstream on top.
    end

endmodule

/* hw/decode_top.sv */
module decode_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    fetch_valid_i,
    input  pipe_pkg::fetch_packet_t fetch_i,
    output logic                    dispatch_valid_o,
    output pipe_pkg::id_dispatch_t  dispatch_o
);

    logic                    fetch_vld_q;
    pipe_pkg::fetch_packet_t fetch_q;
    pipe_pkg::id_dispatch_t  id_rec;

    // fetch side register.
    pipe_reg #(
        .payload_t (pipe_pkg::fetch_packet_t)
    ) u_fetch_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (fetch_valid_i),
        .data_i  (fetch_i),
        .valid_o (fetch_vld_q),
        .data_o  (fetch_q)
    );

    id u_id (
        .valid_i (fetch_vld_q),
        .fetch_i (fetch_q),
        .id_o    (id_rec)
    );

    // dispatch side register.
    pipe_reg #(
        .payload_t (pipe_pkg::id_dispatch_t)
    ) u_disp_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (id_rec.valid),
        .data_i  (id_rec),
        .valid_o (dispatch_valid_o),
        .data_o  (dispatch_o)
    );

endmodule

/* bench/tb_ref.svh */
`ifndef TB_REF_SVH
`define TB_REF_SVH

localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_state = 32'd85862;

// low n bits random with one lfsr step per bit.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v[i]       = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
    end
    return v;
endfunction

function automatic isa_pkg::alu_op_t op_3r(input logic [31:0] w);
    case (w[31:15])
        isa_pkg::OP_3R_ADD_W:   return isa_pkg::ALU_ADD_W;
        isa_pkg::OP_3R_SUB_W:   return isa_pkg::ALU_SUB_W;
        isa_pkg::OP_3R_SLT:     return isa_pkg::ALU_SLT;
        isa_pkg::OP_3R_SLTU:    return isa_pkg::ALU_SLTU;
        isa_pkg::OP_3R_AND:     return isa_pkg::ALU_AND;
        isa_pkg::OP_3R_OR:      return isa_pkg::ALU_OR;
        isa_pkg::OP_3R_XOR:     return isa_pkg::ALU_XOR;
        isa_pkg::OP_3R_SYSCALL: return isa_pkg::ALU_SYSCALL;
        isa_pkg::OP_3R_BREAK:   return isa_pkg::ALU_BREAK;
        default:                return isa_pkg::ALU_NOP;
    endcase
endfunction

function automatic isa_pkg::alu_op_t op_2ri12(input logic [31:0] w);
    case (w[31:22])
        isa_pkg::OP_2RI12_ADDI_W: return isa_pkg::ALU_ADDI_W;
        isa_pkg::OP_2RI12_SLTI:   return isa_pkg::ALU_SLTI;
        isa_pkg::OP_2RI12_ANDI:   return isa_pkg::ALU_ANDI;
        isa_pkg::OP_2RI12_ORI:    return isa_pkg::ALU_ORI;
        isa_pkg::OP_2RI12_LD_W:   return isa_pkg::ALU_LD_W;
        isa_pkg::OP_2RI12_ST_W:   return isa_pkg::ALU_ST_W;
        default:                  return isa_pkg::ALU_NOP;
    endcase
endfunction

function automatic isa_pkg::alu_op_t op_1ri20(input logic [31:0] w);
    case (w[31:25])
        isa_pkg::OP_1RI20_LU12I_W:   return isa_pkg::ALU_LU12I_W;
        isa_pkg::OP_1RI20_PCADDU12I: return isa_pkg::ALU_PCADDU12I;
        default:                     return isa_pkg::ALU_NOP;
    endcase
endfunction

function automatic isa_pkg::alu_op_t op_2ri16(input logic [31:0] w);
    case (w[31:26])
        isa_pkg::OP_2RI16_JIRL: return isa_pkg::ALU_JIRL;
        isa_pkg::OP_2RI16_BEQ:  return isa_pkg::ALU_BEQ;
        isa_pkg::OP_2RI16_BNE:  return isa_pkg::ALU_BNE;
        isa_pkg::OP_2RI16_BLT:  return isa_pkg::ALU_BLT;
        default:                return isa_pkg::ALU_NOP;
    endcase
endfunction

function automatic pipe_pkg::id_dispatch_t ref_decode(input pipe_pkg::fetch_packet_t p);
    pipe_pkg::id_dispatch_t r;
    isa_pkg::alu_op_t       a3;
    isa_pkg::alu_op_t       a12;
    isa_pkg::alu_op_t       a20;
    isa_pkg::alu_op_t       a16;
    isa_pkg::exc_cause_t    dc;
    logic [31:0]            w;
    w   = p.inst;
    r   = '0;
    dc  = isa_pkg::EXC_NOP;
    a3  = op_3r(w);
    a12 = op_2ri12(w);
    a20 = op_1ri20(w);
    a16 = op_2ri16(w);
    if (a3 == isa_pkg::ALU_SYSCALL || a3 == isa_pkg::ALU_BREAK) begin
        r.aluop = a3; // code field ignored.
        dc      = (a3 == isa_pkg::ALU_SYSCALL) ? isa_pkg::EXC_SYS : isa_pkg::EXC_BRK;
    end else if (a3 != isa_pkg::ALU_NOP) begin
        r.aluop     = a3;
        r.rd        = w[4:0];
        r.rj        = w[9:5];
        r.rk        = w[14:10];
        r.reg_write = 1'b1;
    end else if (a12 != isa_pkg::ALU_NOP) begin
        r.aluop     = a12;
        r.rd        = w[4:0];
        r.rj        = w[9:5];
        r.use_imm   = 1'b1;
        r.is_mem    = (a12 == isa_pkg::ALU_LD_W) || (a12 == isa_pkg::ALU_ST_W);
        r.reg_write = (a12 != isa_pkg::ALU_ST_W);
        if (a12 == isa_pkg::ALU_ANDI || a12 == isa_pkg::ALU_ORI) begin
            r.imm = {20'h0, w[21:10]};
        end else begin
            r.imm = {{20{w[21]}}, w[21:10]};
        end
    end else if (a20 != isa_pkg::ALU_NOP) begin
        r.aluop     = a20;
        r.rd        = w[4:0];
        r.use_imm   = 1'b1;
        r.reg_write = 1'b1;
        r.imm       = {w[24:5], 12'h000};
    end else if (a16 != isa_pkg::ALU_NOP) begin
        r.aluop     = a16;
        r.rd        = w[4:0];
        r.rj        = w[9:5];
        r.use_imm   = 1'b1;
        r.is_branch = 1'b1;
        r.reg_write = (a16 == isa_pkg::ALU_JIRL);
        r.imm       = {{14{w[25]}}, w[25:10], 2'b00};
    end else begin
        dc = isa_pkg::EXC_INE;
    end
    r.pc                  = p.pc;
    r.valid               = 1'b1;
    r.pre_is_branch_taken = p.pre_is_branch_taken;
    r.pre_branch_addr     = p.pre_branch_addr;
    r.is_exception        = {p.is_exception, dc != isa_pkg::EXC_NOP};
    r.exception_cause     = {p.exception_cause, dc};
    return r;
endfunction

function automatic logic [31:0] gen_legal();
    logic [31:0] w;
    int          k;
    k = rand_bits(2);
    case (k)
        0: begin
            w = rand_bits(15);
            case (rand_bits(3) % 7)
                0: w[31:15] = isa_pkg::OP_3R_ADD_W;
                1: w[31:15] = isa_pkg::OP_3R_SUB_W;
                2: w[31:15] = isa_pkg::OP_3R_SLT;
                3: w[31:15] = isa_pkg::OP_3R_SLTU;
                4: w[31:15] = isa_pkg::OP_3R_AND;
                5: w[31:15] = isa_pkg::OP_3R_OR;
                default: w[31:15] = isa_pkg::OP_3R_XOR;
            endcase
        end
        1: begin
            w = rand_bits(22);
            case (rand_bits(3) % 6)
                0: w[31:22] = isa_pkg::OP_2RI12_ADDI_W;
                1: w[31:22] = isa_pkg::OP_2RI12_SLTI;
                2: w[31:22] = isa_pkg::OP_2RI12_ANDI;
                3: w[31:22] = isa_pkg::OP_2RI12_ORI;
                4: w[31:22] = isa_pkg::OP_2RI12_LD_W;
                default: w[31:22] = isa_pkg::OP_2RI12_ST_W;
            endcase
        end
        2: begin
            w = rand_bits(25);
            w[31:25] = rand_bits(1) == 0 ? isa_pkg::OP_1RI20_LU12I_W
                                         : isa_pkg::OP_1RI20_PCADDU12I;
        end
        default: begin
            w = rand_bits(26);
            case (rand_bits(2))
                0: w[31:26] = isa_pkg::OP_2RI16_JIRL;
                1: w[31:26] = isa_pkg::OP_2RI16_BEQ;
                2: w[31:26] = isa_pkg::OP_2RI16_BNE;
                default: w[31:26] = isa_pkg::OP_2RI16_BLT;
            endcase
        end
    endcase
    return w;
endfunction

function automatic logic [31:0] gen_sys_brk();
    logic [31:0] w;
    w = rand_bits(15); // code field.
    w[31:15] = rand_bits(1) == 0 ? isa_pkg::OP_3R_SYSCALL : isa_pkg::OP_3R_BREAK;
    return w;
endfunction

function automatic pipe_pkg::fetch_packet_t make_packet(input logic [31:0] inst,
                                                         input bit up_exc);
    pipe_pkg::fetch_packet_t p;
    logic [31:0]             r;
    p      = '0;
    p.inst = inst;
    p.pc   = rand_bits(32);
    r      = rand_bits(1);
    p.pre_is_branch_taken = r[0];
    p.pre_branch_addr     = rand_bits(32);
    if (up_exc) begin
        r = rand_bits(2);
        p.is_exception = r[1:0];
        r = rand_bits(12);
        p.exception_cause = r[11:0];
    end
    return p;
endfunction

// random words until one matches no opcode.
function automatic logic [31:0] gen_illegal();
    logic [31:0]             w;
    pipe_pkg::fetch_packet_t p;
    pipe_pkg::id_dispatch_t  r;
    w = rand_bits(32);
    for (int t = 0; t < 16; t++) begin
        p      = '0;
        p.inst = w;
        r      = ref_decode(p);
        if (r.exception_cause[0] == isa_pkg::EXC_INE) begin
            break;
        end
        w = rand_bits(32);
    end
    return w;
endfunction

`endif

/* bench/tb_decode.sv */
module tb_decode;

    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_ref.svh"

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    flush;
    logic                    fetch_valid;
    pipe_pkg::fetch_packet_t fetch_pkt;
    logic                    dispatch_valid;
    pipe_pkg::id_dispatch_t  dispatch;

    pipe_pkg::id_dispatch_t  exp_q[$];
    int                      exp_cyc_q[$];
    int                      cyc = 0;
    int                      sent = 0;
    int                      received = 0;

    decode_top i_decode_top (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .flush_i          (flush),
        .fetch_valid_i    (fetch_valid),
        .fetch_i          (fetch_pkt),
        .dispatch_valid_o (dispatch_valid),
        .dispatch_o       (dispatch)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_dispatch(input pipe_pkg::id_dispatch_t got,
                                  input pipe_pkg::id_dispatch_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: dispatch record %h, expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_exc(input pipe_pkg::id_dispatch_t got,
                             input pipe_pkg::id_dispatch_t exp);
        if (got.is_exception !== exp.is_exception ||
            got.exception_cause !== exp.exception_cause) begin
            abort_run($sformatf("mismatch at %0t: exc %b/%h, expected %b/%h", $time,
                                got.is_exception, got.exception_cause,
                                exp.is_exception, exp.exception_cause));
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("mismatch at %0t: %0d dispatches, expected %0d",
                                $time, got, exp));
        end
    endtask

    // sampled mid-cycle while the registers are stable.
    always @(negedge clk) begin
        if (rst_n && dispatch_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("dispatch strobe seen with no packet outstanding");
            end
            if (exp_cyc_q[0] != cyc) begin
                abort_run($sformatf("mismatch at %0t: dispatch in cycle %0d, expected %0d",
                                    $time, cyc, exp_cyc_q[0]));
            end
            check_exc(dispatch, exp_q[0]);
            check_dispatch(dispatch, exp_q[0]);
            void'(exp_q.pop_front());
            void'(exp_cyc_q.pop_front());
            received++;
        end
    end

    task automatic send(input logic [31:0] inst, input bit up_exc, input bit with_flush);
        pipe_pkg::fetch_packet_t p;
        @(posedge clk);
        #0.5;
        p           = make_packet(inst, up_exc);
        fetch_pkt   = p;
        fetch_valid = 1'b1;
        flush       = with_flush;
        exp_q.push_back(ref_decode(p));
        exp_cyc_q.push_back(cyc + 2); // two register stages.
        sent++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #0.5;
        fetch_valid = 1'b0;
        flush       = 1'b0;
    endtask

    // packets not yet visible at the output are lost.
    task automatic drop_in_flight();
        while (exp_cyc_q.size() != 0 && exp_cyc_q[$] > cyc) begin
            void'(exp_q.pop_back());
            void'(exp_cyc_q.pop_back());
        end
    endtask

    task automatic wait_drain();
        int i;
        i = 0;
        while (exp_q.size() != 0 && i < 20) begin
            @(posedge clk);
            i++;
        end
        if (exp_q.size() != 0) begin
            abort_run("timeout waiting for outstanding dispatches");
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pkt   = '0;
        repeat (7) @(posedge clk);
        @(negedge clk);
        if (dispatch_valid !== 1'b0) begin
            abort_run("dispatch valid high during reset");
        end
        check_dispatch(dispatch, '0);
        @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        for (int i = 0; i < 80; i++) begin
            send(gen_legal(), 1'b0, 1'b0); // back to back.
        end
        for (int i = 0; i < 16; i++) begin
            send(gen_sys_brk(), 1'b0, 1'b0);
        end
        for (int i = 0; i < 24; i++) begin
            send(gen_illegal(), 1'b0, 1'b0);
        end
        idle_cycle();
        wait_drain();

        // upstream exceptions with random gaps.
        for (int i = 0; i < 40; i++) begin
            case (rand_bits(2))
                0: send(gen_sys_brk(), 1'b1, 1'b0);
                1: send(gen_illegal(), 1'b1, 1'b0);
                default: send(gen_legal(), 1'b1, 1'b0);
            endcase
            if (rand_bits(1) == 1) begin
                idle_cycle();
            end
        end
        idle_cycle();
        wait_drain();

        // flush with packets in both stages and one at the input.
        for (int i = 0; i < 3; i++) begin
            send(gen_legal(), 1'b0, 1'b0);
        end
        send(gen_legal(), 1'b0, 1'b1);
        drop_in_flight();
        idle_cycle();
        for (int i = 0; i < 12; i++) begin
            send(gen_legal(), 1'b0, 1'b0);
        end
        idle_cycle();
        wait_drain();
        repeat (4) @(posedge clk);

        // the fetch stage packet and the input packet never leave.
        check_count(received, sent - 2);
        $display("Verification passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+bench
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/pipe_reg.sv
hw/dec_reg_fmt.sv
hw/dec_imm_fmt.sv
hw/id.sv
hw/decode_top.sv
bench/tb_decode.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_decode -f tb.f -o sim_decode

./obj_dir/sim_decode > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
    echo "simulation PASS"
    exit 0
else
    echo "simulation FAIL"
    exit 1
fi
